// File: logic/rv_core_pkg.sv
package rv_core_pkg;

    // widths that carry a meaning across the core
    typedef logic [31:0] word_t;     // data word, address or instruction
    typedef logic [4:0]  reg_addr_t; // integer register index
    typedef logic [11:0] csr_addr_t; // machine csr address

    typedef enum logic {
        ALU_ADD,    // operand a plus operand b
        ALU_PASS_B  // operand b straight through for lui
    } alu_op_t;

    typedef enum logic {
        OPB_IMM, // immediate from the decoder
        OPB_RS2  // second source register
    } operand_b_sel_t;

    typedef enum logic [1:0] {
        CSR_NONE,  // no csr access
        CSR_WRITE, // csrrw replaces the csr
        CSR_SET    // csrrs ors the source into the csr
    } csr_op_t;

    typedef enum logic [1:0] {
        RES_ALU,  // rd takes the alu result
        RES_CSR,  // rd takes the old csr value
        RES_NONE  // nothing goes to rd
    } result_sel_t;

    typedef enum logic [1:0] {
        FETCH,   // instruction read on the bus
        EXECUTE, // single cycle decode and execute
        STORE    // data write on the bus
    } bus_state_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam word_t CAUSE_ECALL_M = 32'd11; // environment call from machine mode
    localparam word_t CAUSE_ILLEGAL = 32'd2;  // illegal instruction

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // major opcodes of the supported instructions
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam word_t INSTR_ECALL = 32'h0000_0073;
    localparam word_t INSTR_MRET  = 32'h3020_0073;
    localparam word_t INSTR_NOP   = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: logic/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_core_pkg::*; (
    input  word_t          instr,
    output reg_addr_t      rs1,
    output reg_addr_t      rs2,
    output reg_addr_t      rd,
    output word_t          imm,
    output alu_op_t        alu_op,
    output operand_b_sel_t operand_b_sel,
    output csr_op_t        csr_op,
    output csr_addr_t      csr_addr,
    output result_sel_t    result_sel,
    output logic           reg_write,
    output logic           is_store,
    output logic           is_ecall,
    output logic           is_mret,
    output logic           is_illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register fields sit at fixed positions in every format
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign csr_addr = instr[31:20]; // the csr number overlays the i immediate

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        // anything that falls through keeps these quiet defaults
        imm           = imm_i;
        alu_op        = ALU_ADD;
        operand_b_sel = OPB_IMM;
        csr_op        = CSR_NONE;
        result_sel    = RES_NONE;
        reg_write     = 1'b0;
        is_store      = 1'b0;
        is_ecall      = 1'b0;
        is_mret       = 1'b0;
        is_illegal    = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin // addi only
                    result_sel = RES_ALU;
                    reg_write  = 1'b1;
                end else begin
                    is_illegal = 1'b1;
                end
            end
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin // add, not sub
                    operand_b_sel = OPB_RS2;
                    result_sel    = RES_ALU;
                    reg_write     = 1'b1;
                end else begin
                    is_illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                imm        = imm_u;
                alu_op     = ALU_PASS_B; // upper immediate goes to rd unchanged
                result_sel = RES_ALU;
                reg_write  = 1'b1;
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == 3'b010) is_store = 1'b1; // sw is the only store width
                else is_illegal = 1'b1;
            end
            OPC_SYSTEM: begin
                // ecall and mret are matched on the whole word
                if (instr == INSTR_ECALL) begin
                    is_ecall = 1'b1;
                end else if (instr == INSTR_MRET) begin
                    is_mret = 1'b1;
                end else if (funct3 == 3'b001) begin
                    csr_op     = CSR_WRITE;
                    result_sel = RES_CSR;
                    reg_write  = 1'b1;
                end else if (funct3 == 3'b010) begin
                    csr_op     = CSR_SET;
                    result_sel = RES_CSR;
                    reg_write  = 1'b1;
                end else begin
                    is_illegal = 1'b1;
                end
            end
            default: is_illegal = 1'b1;
        endcase
    end

    // the bus master and the trap logic both rely on a single kind per instruction
    a_one_kind: assert final ($onehot0({is_store, is_ecall, is_mret, is_illegal}));

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     rd_wdata,
    input  logic      write_en,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [31:1]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd != '0) begin // a write to x0 is simply lost
            regs[rd] <= rd_wdata;
        end
    end

    // reads are combinational and see the value before this edge's write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_core_pkg::*; (
    input  word_t          rs1_data,
    input  word_t          rs2_data,
    input  word_t          imm,
    input  alu_op_t        alu_op,
    input  operand_b_sel_t operand_b_sel,
    output word_t          alu_result,
    output word_t          store_addr
);

    word_t operand_b;

    assign operand_b = (operand_b_sel == OPB_RS2) ? rs2_data : imm;

    always_comb begin
        case (alu_op)
            ALU_PASS_B: alu_result = operand_b;            // lui
            default:    alu_result = rs1_data + operand_b; // addi and add
        endcase
    end

    // for sw the decoder already hands over the s immediate
    assign store_addr = rs1_data + imm;

endmodule

// File: logic/rv_csr_file.sv
`timescale 1ns/1ns

module rv_csr_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      retire,
    input  csr_op_t   csr_op,
    input  csr_addr_t csr_addr,
    input  word_t     csr_wsrc,
    input  word_t     pc,
    input  logic      is_ecall,
    input  logic      is_mret,
    input  logic      is_illegal,
    output word_t     csr_rdata,
    output word_t     trap_vector,
    output word_t     mepc
);

    word_t mstatus;
    word_t mtvec;
    word_t mcause;
    word_t csr_wdata;
    logic  trap_enter;

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default:     csr_rdata = '0; // unimplemented csrs read as zero
        endcase
    end

    // csrrs builds on the old value that rd also receives
    assign csr_wdata  = (csr_op == CSR_SET) ? (csr_rdata | csr_wsrc) : csr_wsrc;
    assign trap_enter = is_ecall | is_illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (retire) begin
            if (trap_enter) begin
                mepc                      <= pc; // the trapping instruction itself
                mcause                    <= is_ecall ? CAUSE_ECALL_M : CAUSE_ILLEGAL;
                mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                mstatus[MSTATUS_MIE_BIT]  <= 1'b0; // handler runs with interrupts off
            end else if (is_mret) begin
                mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
            end else if (csr_op != CSR_NONE) begin
                case (csr_addr)
                    CSR_MSTATUS: mstatus <= csr_wdata;
                    CSR_MTVEC:   mtvec   <= csr_wdata;
                    CSR_MEPC:    mepc    <= csr_wdata;
                    CSR_MCAUSE:  mcause  <= csr_wdata;
                    default: ; // writes to unknown addresses vanish
                endcase
            end
        end
    end

    assign trap_vector = {mtvec[31:2], 2'b00}; // direct mode only

    a_no_ecall_mret: assert property (@(posedge clk) disable iff (reset)
        !(is_ecall && is_mret));

endmodule

// File: logic/rv_writeback.sv
`timescale 1ns/1ns

module rv_writeback import rv_core_pkg::*; (
    input  word_t       pc,
    input  word_t       alu_result,
    input  word_t       csr_rdata,
    input  word_t       trap_vector,
    input  word_t       mepc,
    input  result_sel_t result_sel,
    input  logic        is_ecall,
    input  logic        is_illegal,
    input  logic        is_mret,
    output word_t       rd_wdata,
    output word_t       next_pc
);

    always_comb begin
        case (result_sel)
            RES_ALU: rd_wdata = alu_result;
            RES_CSR: rd_wdata = csr_rdata; // value before the csr write
            default: rd_wdata = '0;        // reg_write is low in this case anyway
        endcase
    end

    always_comb begin
        // traps win over the sequential pc
        if (is_ecall || is_illegal) begin
            next_pc = trap_vector;
        end else if (is_mret) begin
            next_pc = mepc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

endmodule

// File: logic/rv_bus_master.sv
`timescale 1ns/1ns

module rv_bus_master import rv_core_pkg::*; #(
    parameter word_t RESET_PC = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output logic [3:0] wb_sel,
    output word_t      wb_wdata,
    input  word_t      wb_rdata,
    input  logic       wb_ack,
    input  word_t      next_pc,
    input  logic       is_store,
    input  word_t      store_addr,
    input  word_t      store_data,
    output word_t      pc,
    output word_t      instr,
    output logic       retire
);

    bus_state_t state;

    assign wb_sel = 4'hf; // only whole words move

    // a non store retires in its one execute cycle and a store on its write ack
    assign retire = (state == EXECUTE && !is_store) || (state == STORE && wb_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            pc     <= RESET_PC;
            instr  <= INSTR_NOP; // decode sees a harmless word until the first fetch
        end else begin
            case (state)
                FETCH: begin
                    if (!wb_cyc) begin // bus is idle so the read request goes out
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        instr  <= wb_rdata;
                        state  <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_store) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b1;
                        state  <= STORE;
                    end else begin
                        pc    <= next_pc;
                        state <= FETCH;
                    end
                end
                STORE: begin
                    if (wb_ack) begin // slow slaves just keep us here
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        pc     <= next_pc;
                        state  <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // address and write data are loaded only when a request is launched
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_adr   <= '0;
            wb_wdata <= '0;
        end else if (state == FETCH && !wb_cyc) begin
            wb_adr <= pc;
        end else if (state == EXECUTE && is_store) begin
            wb_adr   <= store_addr;
            wb_wdata <= store_data;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

    // a pending request holds its strobe and address until the slave acks
    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

// File: logic/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_core_pkg::*; #(
    parameter word_t RESET_PC = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output logic [3:0] wb_sel,
    output word_t      wb_wdata,
    input  word_t      wb_rdata,
    input  logic       wb_ack
);

    word_t          pc;
    word_t          instr;
    logic           retire;
    reg_addr_t      rs1;
    reg_addr_t      rs2;
    reg_addr_t      rd;
    word_t          imm;
    alu_op_t        alu_op;
    operand_b_sel_t operand_b_sel;
    csr_op_t        csr_op;
    csr_addr_t      csr_addr;
    result_sel_t    result_sel;
    logic           reg_write;
    logic           is_store;
    logic           is_ecall;
    logic           is_mret;
    logic           is_illegal;
    word_t          rs1_data;
    word_t          rs2_data;
    word_t          alu_result;
    word_t          store_addr;
    word_t          csr_rdata;
    word_t          trap_vector;
    word_t          mepc;
    word_t          rd_wdata;
    word_t          next_pc;

    // ports share their names with the nets above so most of the wiring is implicit
    rv_bus_master #(.RESET_PC(RESET_PC)) i_bus_master (.*, .store_data(rs2_data));

    rv_decode i_decode (.*);

    // the register write lands only on the retiring edge
    rv_regfile i_regfile (.*, .write_en(reg_write && retire));

    rv_execute i_execute (.*);

    rv_csr_file i_csr_file (.*, .csr_wsrc(rs1_data)); // csr source is always rs1

    rv_writeback i_writeback (.*);

endmodule

// File: sim/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;

    localparam logic [31:0] SEED = 32'h9af6;

    // base isa and zicsr encodings used to assemble the program
    localparam logic [6:0]  OP_IMM         = 7'b0010011;
    localparam logic [6:0]  OP_REG         = 7'b0110011;
    localparam logic [6:0]  OP_LUI         = 7'b0110111;
    localparam logic [6:0]  OP_STORE       = 7'b0100011;
    localparam logic [6:0]  OP_SYSTEM      = 7'b1110011;
    localparam logic [2:0]  F3_CSRRW       = 3'b001;
    localparam logic [2:0]  F3_CSRRS       = 3'b010;
    localparam logic [31:0] ECALL_WORD     = 32'h0000_0073;
    localparam logic [31:0] MRET_WORD      = 32'h3020_0073;
    localparam logic [31:0] UNDEFINED_WORD = 32'hffff_ffff; // opcode 7f is not an instruction here
    localparam logic [11:0] MSTATUS        = 12'h300;
    localparam logic [11:0] MTVEC          = 12'h305;
    localparam logic [11:0] MEPC           = 12'h341;
    localparam logic [11:0] MCAUSE         = 12'h342;
    localparam logic [11:0] UNKNOWN_CSR    = 12'h7c0;

    // operands of the test program
    localparam logic [11:0] ADDI_A       = 12'h123;
    localparam logic [11:0] ADDI_B       = 12'hffb;  // minus five
    localparam logic [19:0] LUI_IMM      = 20'habcde;
    localparam logic [11:0] MTVEC_IMM    = 12'h101;  // low bits set so the vector has to clear them
    localparam logic [31:0] HANDLER      = {20'h0, MTVEC_IMM[11:2], 2'b00};
    localparam logic [31:0] ECALL_PC     = 32'h54;
    localparam logic [31:0] UNDEFINED_PC = 32'h64;
    localparam logic [31:0] MIE          = 32'h8;    // mstatus bit 3
    localparam logic [31:0] MPIE         = 32'h80;   // mstatus bit 7

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    logic [31:0] mem [0:255];        // word addressed, 1 KiB
    logic [31:0] prog_adr [$];
    logic [31:0] prog_word [$];
    logic [31:0] exp_pc [$];         // fetch addresses in execution order
    logic [31:0] exp_store_adr [$];
    logic [31:0] exp_store_dat [$];
    logic [31:0] emit_addr;

    logic        waiting;            // a request has been seen and is not acked yet
    int unsigned wait_left;
    logic [31:0] req_adr;
    logic        done;
    int          fetch_idx;
    int          store_idx;
    int          retires;            // retire pulses since the last fetch began
    int          errors;
    int          checks;
    int          cycles;

    rv_core_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [4:0] rd);
        return {7'b0000000, rs2, rs1, 3'b000, rd, OP_REG}; // add
    endfunction

    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}; // sw
    endfunction

    function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    task emit(input logic [31:0] word);
        prog_adr.push_back(emit_addr);
        prog_word.push_back(word);
        emit_addr += 32'd4;
    endtask

    task add_pc_range(input logic [31:0] first, input logic [31:0] last);
        for (logic [31:0] a = first; a <= last; a += 32'd4) begin
            exp_pc.push_back(a);
        end
    endtask

    task queue_store(input logic [31:0] adr, input logic [31:0] dat);
        exp_store_adr.push_back(adr);
        exp_store_dat.push_back(dat);
    endtask

    task write_program;
        emit_addr = 32'h0;
        emit(itype_word(ADDI_A, 0, 3'b000, 1, OP_IMM));
        emit(itype_word(ADDI_B, 0, 3'b000, 2, OP_IMM));
        emit(rtype_word(2, 1, 3));                                // x3 = x1 + x2
        emit(utype_word(LUI_IMM, 4));
        emit(itype_word(12'h055, 0, 3'b000, 0, OP_IMM));          // write to x0 must vanish
        emit(stype_word(12'h200, 3, 0));
        emit(stype_word(12'h204, 4, 0));
        emit(stype_word(12'h208, 0, 0));
        emit(itype_word(MTVEC_IMM, 0, 3'b000, 5, OP_IMM));
        emit(itype_word(MTVEC, 5, F3_CSRRW, 6, OP_SYSTEM));       // x6 gets the old mtvec
        emit(itype_word(MTVEC, 0, F3_CSRRS, 7, OP_SYSTEM));       // plain read back
        emit(stype_word(12'h20c, 6, 0));
        emit(stype_word(12'h210, 7, 0));
        emit(itype_word(12'h008, 0, 3'b000, 8, OP_IMM));
        emit(itype_word(MSTATUS, 8, F3_CSRRS, 9, OP_SYSTEM));     // set mie
        emit(itype_word(MSTATUS, 0, F3_CSRRS, 10, OP_SYSTEM));
        emit(stype_word(12'h214, 9, 0));
        emit(stype_word(12'h218, 10, 0));
        emit(itype_word(UNKNOWN_CSR, 1, F3_CSRRW, 11, OP_SYSTEM));
        emit(itype_word(UNKNOWN_CSR, 0, F3_CSRRS, 12, OP_SYSTEM));
        emit(stype_word(12'h21c, 12, 0));
        emit(ECALL_WORD);                                         // lands at ECALL_PC
        emit(itype_word(MSTATUS, 0, F3_CSRRS, 16, OP_SYSTEM));    // mret comes back here
        emit(stype_word(12'h22c, 16, 0));
        emit(itype_word(MSTATUS, 0, F3_CSRRW, 0, OP_SYSTEM));     // clear mie and mpie
        emit(UNDEFINED_WORD);                                     // lands at UNDEFINED_PC
        emit(stype_word(12'h230, 31, 0));
        emit(stype_word(12'h234, 1, 0));
        emit(itype_word(MSTATUS, 0, F3_CSRRS, 17, OP_SYSTEM));    // mret has just set mpie
        emit(stype_word(12'h238, 17, 0));
        // trap handler dumps the trap csrs and returns past the trapping word
        emit_addr = HANDLER;
        emit(itype_word(MEPC, 0, F3_CSRRS, 13, OP_SYSTEM));
        emit(itype_word(MCAUSE, 0, F3_CSRRS, 14, OP_SYSTEM));
        emit(itype_word(MSTATUS, 0, F3_CSRRS, 15, OP_SYSTEM));
        emit(stype_word(12'h220, 13, 0));
        emit(stype_word(12'h224, 14, 0));
        emit(stype_word(12'h228, 15, 0));
        emit(itype_word(12'h004, 13, 3'b000, 13, OP_IMM));
        emit(itype_word(MEPC, 13, F3_CSRRW, 0, OP_SYSTEM));
        emit(MRET_WORD);
    endtask

    task list_expected;
        add_pc_range(32'h0, ECALL_PC);
        add_pc_range(HANDLER, HANDLER + 32'h20);
        add_pc_range(ECALL_PC + 32'd4, UNDEFINED_PC);
        add_pc_range(HANDLER, HANDLER + 32'h20);
        add_pc_range(UNDEFINED_PC + 32'd4, UNDEFINED_PC + 32'h10);
        queue_store(32'h200, sext12(ADDI_A) + sext12(ADDI_B));
        queue_store(32'h204, {LUI_IMM, 12'h000});
        queue_store(32'h208, 32'h0);
        queue_store(32'h20c, 32'h0);            // mtvec before the csrrw
        queue_store(32'h210, sext12(MTVEC_IMM)); // the register itself keeps its low bits
        queue_store(32'h214, 32'h0);
        queue_store(32'h218, MIE);
        queue_store(32'h21c, 32'h0);
        queue_store(32'h220, ECALL_PC);
        queue_store(32'h224, 32'd11);
        queue_store(32'h228, MPIE);             // mie cleared and mpie holds the old mie
        queue_store(32'h22c, MIE | MPIE);
        queue_store(32'h220, UNDEFINED_PC);
        queue_store(32'h224, 32'd2);
        queue_store(32'h228, 32'h0);            // mie was clear so mpie stays clear
        queue_store(32'h230, 32'h0);            // rd of the undefined word was never written
        queue_store(32'h234, sext12(ADDI_A));
        queue_store(32'h238, MPIE);             // mie restored as clear and mpie set again
    endtask

    task fetch_seen;
        checks++;
        if (fetch_idx >= exp_pc.size()) begin
            errors++;
            $display("fetch from %h runs past the end of the expected pc sequence", wb_adr);
        end else if (wb_adr !== exp_pc[fetch_idx]) begin
            errors++;
            $display("CHECK FAILED: wb_adr fetch %0d got %h expected %h",
                     fetch_idx, wb_adr, exp_pc[fetch_idx]);
        end
        if (retires != ((fetch_idx == 0) ? 0 : 1)) begin // exactly one retire per fetch
            errors++;
            $display("CHECK FAILED: retire count before fetch %0d got %h expected %h",
                     fetch_idx, retires, (fetch_idx == 0) ? 0 : 1);
        end
        retires = 0;
        fetch_idx++;
    endtask

    task store_acked;
        checks++;
        if (store_idx >= exp_store_adr.size()) begin
            errors++;
            $display("unexpected bus write of %h to %h after the last expected store",
                     wb_wdata, wb_adr);
        end else begin
            if (wb_adr !== exp_store_adr[store_idx]) begin
                errors++;
                $display("CHECK FAILED: wb_adr store %0d got %h expected %h",
                         store_idx, wb_adr, exp_store_adr[store_idx]);
            end
            if (wb_wdata !== exp_store_dat[store_idx]) begin
                errors++;
                $display("CHECK FAILED: wb_wdata store %0d got %h expected %h",
                         store_idx, wb_wdata, exp_store_dat[store_idx]);
            end
        end
        if (wb_sel !== 4'hf) begin
            errors++;
            $display("CHECK FAILED: wb_sel got %h expected %h", wb_sel, 4'hf);
        end
        mem[wb_adr[9:2]] = wb_wdata;
        store_idx++;
        if (store_idx == exp_store_adr.size()) done <= 1'b1;
    endtask

    // wishbone slave with 0 to 3 random wait states on top of the minimum latency
    always @(posedge clk) begin
        if (reset) begin
            wb_ack  <= 1'b0;
            waiting <= 1'b0;
        end else begin
            if (i_dut.retire) retires++;
            if (wb_ack) begin
                wb_ack <= 1'b0; // the master drops its strobe on this edge
            end else if (wb_cyc && wb_stb) begin
                if (!waiting) begin
                    waiting   <= 1'b1;
                    wait_left <= $urandom_range(3, 0);
                    req_adr   <= wb_adr;
                    if (!wb_we) fetch_seen();
                end else begin
                    if (wb_adr !== req_adr) begin
                        errors++;
                        $display("CHECK FAILED: wb_adr got %h expected %h while waiting for ack",
                                 wb_adr, req_adr);
                    end
                    if (wait_left != 0) begin
                        wait_left <= wait_left - 1;
                    end else begin
                        waiting <= 1'b0;
                        wb_ack  <= 1'b1;
                        if (wb_we) store_acked();
                        else wb_rdata <= mem[wb_adr[9:2]];
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        wb_ack    = 1'b0;
        wb_rdata  = '0;
        done      = 1'b0;
        waiting   = 1'b0;
        wait_left = 0;
        req_adr   = '0;
        fetch_idx = 0;
        store_idx = 0;
        retires   = 0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hbad0_0000 | (i << 2); // unused words carry their own byte address
        end
        write_program();
        list_expected();
        for (int i = 0; i < prog_adr.size(); i++) begin
            mem[prog_adr[i][9:2]] = prog_word[i];
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (!done && cycles < exp_pc.size() * 12) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("timeout, program did not finish within %0d cycles", cycles);
        end else if (fetch_idx != exp_pc.size()) begin
            errors++;
            $display("saw %0d fetches but the program should make %0d", fetch_idx, exp_pc.size());
        end
        $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_csr_file.sv
logic/rv_writeback.sv
logic/rv_bus_master.sv
logic/rv_core_top.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/rv_decode.sv
  - logic/rv_regfile.sv
  - logic/rv_execute.sv
  - logic/rv_csr_file.sv
  - logic/rv_writeback.sv
  - logic/rv_bus_master.sv
  - logic/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_core_tb.sv
